// File: adc_lane_pkg.sv
/*
 * adc lane package: lane, channel and frame constants of the serial ADC
 * interface as seen after the deserializer
 */
package adc_lane_pkg;

  localparam int LANE_BITS    = 10;               // bits per deserialized lane
  localparam int NUM_LANES    = 9;                // 8 sample lanes + frame lane
  localparam int NUM_CHANNELS = 8;                // sample channels only
  localparam int RAW_BITS     = LANE_BITS * NUM_LANES; // 90-bit deserializer bus
  localparam int FRAME_LANE   = 8;                // frame clock sits on the top lane

  // frame clock is sampled like data, so an aligned frame reads as 5 ones over 5 zeros
  localparam logic [LANE_BITS-1:0] FRAME_PATTERN = 10'b11111_00000;

  // quiet cycles after a slip so the iserdes can shift before we judge again
  localparam logic [2:0] SLIP_HOLDOFF = 3'd4;

  typedef logic [LANE_BITS-1:0] lane_t;           // one lane word

endpackage

// File: adc_stream_pkg.sv
/*
 * adc stream package: beat layout, return FIFO, credit and debug capture
 * constants shared by the window return path and the capture logic
 */
package adc_stream_pkg;

  localparam int SAMPLE_BITS = 16;                // packed channel word width

  typedef logic [SAMPLE_BITS-1:0] cap_word_t;     // one capture word, same as a channel word

  // one beat carries all channels, channel n at [n]
  typedef logic [adc_lane_pkg::NUM_CHANNELS-1:0][SAMPLE_BITS-1:0] beat_t;

  localparam int FIFO_DEPTH  = 8;                 // return FIFO entries
  localparam int CREDIT_BITS = 4;                 // wide enough for FIFO_DEPTH

  // window starts with one credit per FIFO entry
  localparam logic [CREDIT_BITS-1:0] WIN_CREDITS = CREDIT_BITS'(FIFO_DEPTH);

  // downstream consumer buffer size
  localparam logic [CREDIT_BITS-1:0] DN_CREDITS = 4'd4;

  localparam int CAPTURE_DEPTH = 64;              // capture memory entries
  localparam int CAP_ADDR_BITS = $clog2(CAPTURE_DEPTH);

  // capture select codes, any other code picks lane n
  localparam logic [2:0] SEL_RETURN = 3'd1;       // channel 0 of returned window data

  // zero-extend a lane word into a channel word
  localparam int PAD_BITS = SAMPLE_BITS - adc_lane_pkg::LANE_BITS;

endpackage

// File: adc_lane_unpack.sv
/*
 * adc lane unpack: transposes the deserializer bus into nine lanes and
 * registers them together with the zero-extended window feed
 */
`timescale 1ns/1ns
module adc_lane_unpack (
  input  logic                                           clk_adc,
  input  logic                                           rst_adc_n,
  input  logic [adc_lane_pkg::RAW_BITS-1:0]              data_in,
  input  logic                                           sampling,
  input  logic                                           frame_last,
  output adc_lane_pkg::lane_t [adc_lane_pkg::NUM_LANES-1:0] lanes,
  output adc_stream_pkg::beat_t                          win_data,
  output logic                                           win_valid,
  output logic                                           win_last
);

  adc_lane_pkg::lane_t [adc_lane_pkg::NUM_LANES-1:0] lanes_c; // transposed, before the flops
  adc_stream_pkg::beat_t                             win_c;   // packed window beat

  // serdes interleaves lanes bit by bit, bit j of lane k sits at j*9+k
  always_comb begin
    for (int k = 0; k < adc_lane_pkg::NUM_LANES; k++) begin
      for (int j = 0; j < adc_lane_pkg::LANE_BITS; j++) begin
        lanes_c[k][j] = data_in[j*adc_lane_pkg::NUM_LANES + k];
      end
    end
    for (int n = 0; n < adc_lane_pkg::NUM_CHANNELS; n++) begin
      win_c[n] = {{adc_stream_pkg::PAD_BITS{1'b0}}, lanes_c[n]}; // frame lane not forwarded
    end
  end

  always_ff @(posedge clk_adc) begin
    lanes    <= lanes_c;                          // payload, no reset
    win_data <= win_c;
  end

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      win_valid <= 1'b0;
      win_last  <= 1'b0;
    end else begin
      win_valid <= sampling;                      // aligned with win_data
      win_last  <= frame_last;
    end
  end

endmodule

// File: frame_slip_detect.sv
/*
 * frame slip detect: checks the registered frame lane against the expected
 * pattern and pulses bitslip, then holds off while the deserializer shifts
 */
`timescale 1ns/1ns
module frame_slip_detect (
  input  logic                clk_adc,
  input  logic                rst_adc_n,
  input  adc_lane_pkg::lane_t frame_lane,
  output logic                bitslip
);

  logic [$bits(adc_lane_pkg::SLIP_HOLDOFF)-1:0] holdoff; // quiet cycles left
  logic                                         mismatch;
  logic                                         slip_now;

  assign mismatch = (frame_lane != adc_lane_pkg::FRAME_PATTERN);
  assign slip_now = mismatch && (holdoff == '0);  // only judge when idle

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      bitslip <= 1'b0;
      holdoff <= '0;
    end else begin
      bitslip <= slip_now;                        // single cycle request
      if (slip_now) begin
        holdoff <= adc_lane_pkg::SLIP_HOLDOFF;    // restart quiet window
      end else if (holdoff != '0) begin
        holdoff <= holdoff - 1'b1;
      end
    end
  end

  // Holdoff loads on the same edge that raises bitslip, so the next
  // request can come no earlier than SLIP_HOLDOFF+1 cycles later.

endmodule

// File: return_fifo.sv
/*
 * return FIFO: circular buffer for beats coming back from the window,
 * head always visible, one registered credit pulse per pop
 */
`timescale 1ns/1ns
module return_fifo (
  input  logic                  clk_adc,
  input  logic                  rst_adc_n,
  input  logic                  ret_valid,
  input  adc_stream_pkg::beat_t ret_data,
  input  logic                  ret_last,
  input  logic                  pop,
  output adc_stream_pkg::beat_t head_data,
  output logic                  head_last,
  output logic                  empty,
  output logic                  ret_credit
);

  adc_stream_pkg::beat_t                             mem_data [adc_stream_pkg::FIFO_DEPTH];
  logic                                              mem_last [adc_stream_pkg::FIFO_DEPTH];
  logic [$clog2(adc_stream_pkg::FIFO_DEPTH)-1:0]     wr_ptr;   // wraps, depth is 2^n
  logic [$clog2(adc_stream_pkg::FIFO_DEPTH)-1:0]     rd_ptr;
  logic [$clog2(adc_stream_pkg::FIFO_DEPTH):0]       count;    // 0..FIFO_DEPTH
  logic                                              do_pop;

  assign empty     = (count == '0);
  assign do_pop    = pop && !empty;               // pop on empty is ignored
  assign head_data = mem_data[rd_ptr];            // show-ahead
  assign head_last = mem_last[rd_ptr];

  // storage, window owns the credits so no full check here
  always_ff @(posedge clk_adc) begin
    if (ret_valid) begin
      mem_data[wr_ptr] <= ret_data;
      mem_last[wr_ptr] <= ret_last;
    end
  end

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      ret_credit <= 1'b0;
    end else begin
      if (ret_valid) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)    rd_ptr <= rd_ptr + 1'b1;
      case ({ret_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                  // idle or push+pop
      endcase
      ret_credit <= do_pop;                       // freed slot goes back to window
    end
  end

endmodule

// File: stream_credit_tx.sv
/*
 * stream credit transmitter: pops the return FIFO while downstream credits
 * remain and registers each popped beat onto the downstream port
 */
`timescale 1ns/1ns
module stream_credit_tx (
  input  logic                  clk_adc,
  input  logic                  rst_adc_n,
  input  adc_stream_pkg::beat_t head_data,
  input  logic                  head_last,
  input  logic                  empty,
  input  logic                  dn_credit,
  output logic                  pop,
  output logic                  dn_valid,
  output adc_stream_pkg::beat_t dn_data,
  output logic                  dn_last
);

  logic [adc_stream_pkg::CREDIT_BITS-1:0] credits; // free slots at the consumer

  // a credit arriving this cycle can be spent right away
  assign pop = !empty && ((credits != '0) || dn_credit);

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      credits  <= adc_stream_pkg::DN_CREDITS;
      dn_valid <= 1'b0;
      dn_last  <= 1'b0;
    end else begin
      if (pop && !dn_credit) begin
        credits <= credits - 1'b1;
      end else if (!pop && dn_credit) begin
        credits <= credits + 1'b1;
      end
      dn_valid <= pop;                            // one cycle after the pop
      dn_last  <= pop && head_last;
    end
  end

  always_ff @(posedge clk_adc) begin
    if (pop) dn_data <= head_data;                // held between beats
  end

endmodule

// File: capture_ctrl.sv
/*
 * capture control: arms on capture_go, starts on the next frame end of the
 * selected source, then writes CAPTURE_DEPTH registered words
 */
`timescale 1ns/1ns
module capture_ctrl (
  input  logic                                              clk_adc,
  input  logic                                              rst_adc_n,
  input  logic                                              capture_go,
  input  logic [2:0]                                        capture_sel,
  input  adc_lane_pkg::lane_t [adc_lane_pkg::NUM_LANES-1:0] lanes,
  input  logic                                              win_valid,
  input  logic                                              win_last,
  input  logic                                              ret_valid,
  input  logic                                              ret_last,
  input  adc_stream_pkg::beat_t                             ret_data,
  output logic                                              wr_en,
  output logic [adc_stream_pkg::CAP_ADDR_BITS-1:0]          wr_addr,
  output adc_stream_pkg::cap_word_t                         wr_data,
  output logic                                              capture_busy,
  output logic                                              capture_done
);

  logic armed;                                    // waiting for frame end
  logic sel_ret;                                  // capturing the return path
  logic frame_end;
  logic last_word;

  assign sel_ret   = (capture_sel == adc_stream_pkg::SEL_RETURN);
  assign frame_end = sel_ret ? (ret_valid && ret_last) : (win_valid && win_last);
  assign last_word = (int'(wr_addr) == adc_stream_pkg::CAPTURE_DEPTH - 1);
  assign wr_en     = capture_busy;                // one word per busy cycle

  // source mux, registered every cycle so writes see last cycle's value
  always_ff @(posedge clk_adc) begin
    if (sel_ret) begin
      wr_data <= ret_data[0];                     // channel 0 of the window output
    end else begin
      wr_data <= {{adc_stream_pkg::PAD_BITS{1'b0}}, lanes[capture_sel]};
    end
  end

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      armed        <= 1'b0;
      capture_busy <= 1'b0;
      capture_done <= 1'b0;
      wr_addr      <= '0;
    end else if (capture_go) begin
      armed        <= 1'b1;                       // restart even mid-capture
      capture_busy <= 1'b0;
      capture_done <= 1'b0;
      wr_addr      <= '0;
    end else if (armed && frame_end) begin
      armed        <= 1'b0;
      capture_busy <= 1'b1;                       // first write next cycle
    end else if (capture_busy) begin
      if (last_word) begin
        capture_busy <= 1'b0;
        capture_done <= 1'b1;                     // sticky until next go
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

endmodule

// File: capture_ram.sv
/*
 * capture memory: CAPTURE_DEPTH x 16 words, one write port and one
 * registered read port
 */
`timescale 1ns/1ns
module capture_ram (
  input  logic                                     clk_adc,
  input  logic                                     wr_en,
  input  logic [adc_stream_pkg::CAP_ADDR_BITS-1:0] wr_addr,
  input  adc_stream_pkg::cap_word_t                wr_data,
  input  logic [adc_stream_pkg::CAP_ADDR_BITS-1:0] rd_addr,
  output adc_stream_pkg::cap_word_t                rd_data
);

  adc_stream_pkg::cap_word_t mem [adc_stream_pkg::CAPTURE_DEPTH]; // maps to block ram

  always_ff @(posedge clk_adc) begin
    if (wr_en) mem[wr_addr] <= wr_data;
    rd_data <= mem[rd_addr];                      // one cycle read latency
  end

endmodule

// File: adc_input_top.sv
/*
 * adc input top: receive front end of the eight channel serial ADC with
 * unpack, frame alignment, window return path and debug capture
 */
`timescale 1ns/1ns
module adc_input_top (
  input  logic                                     clk_adc,
  input  logic                                     rst_adc_n,
  input  logic [adc_lane_pkg::RAW_BITS-1:0]        data_in,      // from deserializer
  input  logic                                     sampling,
  input  logic                                     frame_last,
  input  logic                                     ret_valid,    // back from window
  input  adc_stream_pkg::beat_t                    ret_data,
  input  logic                                     ret_last,
  input  logic                                     dn_credit,    // from downstream
  input  logic                                     capture_go,
  input  logic [2:0]                               capture_sel,
  input  logic [adc_stream_pkg::CAP_ADDR_BITS-1:0] cap_rd_addr,
  output logic                                     bitslip,      // to deserializer
  output adc_stream_pkg::beat_t                    win_data,     // to window
  output logic                                     win_valid,
  output logic                                     win_last,
  output logic                                     ret_credit,   // to window
  output logic                                     dn_valid,     // to downstream
  output adc_stream_pkg::beat_t                    dn_data,
  output logic                                     dn_last,
  output adc_stream_pkg::cap_word_t                cap_rd_data,
  output logic                                     capture_busy,
  output logic                                     capture_done
);

  adc_lane_pkg::lane_t [adc_lane_pkg::NUM_LANES-1:0] lanes;   // registered lanes
  adc_stream_pkg::beat_t                             head_data;
  logic                                              head_last;
  logic                                              empty;
  logic                                              pop;
  logic                                              cap_wr_en;
  logic [adc_stream_pkg::CAP_ADDR_BITS-1:0]          cap_wr_addr;
  adc_stream_pkg::cap_word_t                         cap_wr_data;

  adc_lane_unpack unpack_inst (
    .clk_adc    (clk_adc),
    .rst_adc_n  (rst_adc_n),
    .data_in    (data_in),
    .sampling   (sampling),
    .frame_last (frame_last),
    .lanes      (lanes),
    .win_data   (win_data),
    .win_valid  (win_valid),
    .win_last   (win_last)
  );

  frame_slip_detect slip_inst (
    .clk_adc    (clk_adc),
    .rst_adc_n  (rst_adc_n),
    .frame_lane (lanes[adc_lane_pkg::FRAME_LANE]),
    .bitslip    (bitslip)
  );

  return_fifo fifo_inst (
    .clk_adc    (clk_adc),
    .rst_adc_n  (rst_adc_n),
    .ret_valid  (ret_valid),
    .ret_data   (ret_data),
    .ret_last   (ret_last),
    .pop        (pop),
    .head_data  (head_data),
    .head_last  (head_last),
    .empty      (empty),
    .ret_credit (ret_credit)
  );

  stream_credit_tx tx_inst (
    .clk_adc    (clk_adc),
    .rst_adc_n  (rst_adc_n),
    .head_data  (head_data),
    .head_last  (head_last),
    .empty      (empty),
    .dn_credit  (dn_credit),
    .pop        (pop),
    .dn_valid   (dn_valid),
    .dn_data    (dn_data),
    .dn_last    (dn_last)
  );

  capture_ctrl capture_ctrl_inst (
    .clk_adc      (clk_adc),
    .rst_adc_n    (rst_adc_n),
    .capture_go   (capture_go),
    .capture_sel  (capture_sel),
    .lanes        (lanes),
    .win_valid    (win_valid),
    .win_last     (win_last),
    .ret_valid    (ret_valid),
    .ret_last     (ret_last),
    .ret_data     (ret_data),
    .wr_en        (cap_wr_en),
    .wr_addr      (cap_wr_addr),
    .wr_data      (cap_wr_data),
    .capture_busy (capture_busy),
    .capture_done (capture_done)
  );

  capture_ram capture_ram_inst (
    .clk_adc (clk_adc),
    .wr_en   (cap_wr_en),
    .wr_addr (cap_wr_addr),
    .wr_data (cap_wr_data),
    .rd_addr (cap_rd_addr),
    .rd_data (cap_rd_data)
  );

endmodule

// File: adc_input_assertions.sv
/*
 * adc input assertions: credit, bitslip spacing, FIFO overflow and capture
 * address checks on the front end
 */
`timescale 1ns/1ns
module adc_input_assertions (
  input logic                                     clk_adc,
  input logic                                     rst_adc_n,
  input logic                                     pop,
  input logic                                     dn_credit,
  input logic                                     bitslip,
  input logic                                     ret_valid,
  input logic [$clog2(adc_stream_pkg::FIFO_DEPTH):0] fifo_count,
  input logic                                     wr_en,
  input logic [adc_stream_pkg::CAP_ADDR_BITS-1:0] wr_addr
);

  int fail_count = 0;                             // failed assertions so far
  int dn_avail;                                   // credits granted and not yet spent

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      dn_avail <= int'(adc_stream_pkg::DN_CREDITS);
    end else begin
      dn_avail <= dn_avail + int'(dn_credit) - int'(pop);
    end
  end

  // a pop needs a granted credit or one arriving now
  assert property (@(posedge clk_adc) disable iff (!rst_adc_n)
    pop |-> (dn_avail > 0) || dn_credit)
    else begin
      fail_count++;
      $error("pop without downstream credit");
    end

  // slip requests stay SLIP_HOLDOFF cycles apart
  assert property (@(posedge clk_adc) disable iff (!rst_adc_n)
    bitslip |-> !$past(bitslip, 1) && !$past(bitslip, 2) && !$past(bitslip, 3)
                && !$past(bitslip, 4))
    else begin
      fail_count++;
      $error("bitslip repeated inside the holdoff");
    end

  assert property (@(posedge clk_adc) disable iff (!rst_adc_n)
    ret_valid |-> int'(fifo_count) < adc_stream_pkg::FIFO_DEPTH)
    else begin
      fail_count++;
      $error("return beat written into a full FIFO");
    end

  // a capture starts at the first entry
  assert property (@(posedge clk_adc) disable iff (!rst_adc_n)
    $rose(wr_en) |-> wr_addr == '0)
    else begin
      fail_count++;
      $error("capture did not start at address zero");
    end

  // and stops after the last one instead of wrapping
  assert property (@(posedge clk_adc) disable iff (!rst_adc_n)
    wr_en && (int'(wr_addr) == adc_stream_pkg::CAPTURE_DEPTH - 1) |=> !wr_en)
    else begin
      fail_count++;
      $error("capture wrote past the last address");
    end

endmodule

bind adc_input_top adc_input_assertions assertions_inst (
  .clk_adc    (clk_adc),
  .rst_adc_n  (rst_adc_n),
  .pop        (pop),
  .dn_credit  (dn_credit),
  .bitslip    (bitslip),
  .ret_valid  (ret_valid),
  .fifo_count (fifo_inst.count),
  .wr_en      (cap_wr_en),
  .wr_addr    (cap_wr_addr)
);

// File: adc_input_tb.sv
/*
 * adc input testbench: trace-driven checks of unpack, frame slip, credit
 * return path and debug capture of the receive front end
 */
`timescale 1ns/1ns
module adc_input_tb;

  logic clk_adc, rst_adc_n, sampling, frame_last, ret_valid, ret_last, dn_credit, capture_go;
  logic [adc_lane_pkg::RAW_BITS-1:0]                 data_in;
  adc_stream_pkg::beat_t                             ret_data, win_data, dn_data;
  logic [2:0]                                        capture_sel;
  logic [adc_stream_pkg::CAP_ADDR_BITS-1:0]          cap_rd_addr;
  adc_stream_pkg::cap_word_t                         cap_rd_data;
  logic bitslip, win_valid, win_last, ret_credit, dn_valid, dn_last, capture_busy, capture_done;

  adc_lane_pkg::lane_t [adc_lane_pkg::NUM_LANES-1:0] p1_lanes; // word waiting for win check
  logic  p1_valid, p1_s, p1_f, p1_e, p2_valid, p2_e;            // e is expected bitslip
  adc_stream_pkg::beat_t exp_beats[$];                          // downstream scoreboard
  logic  exp_lasts[$];
  int    win_credits, ret_pulses, dn_count, granted, owed, gap, hold_cycles;
  int    beat_errs, lane_errs, cap_errs, bit_errs, other_errs;
  int    cycle_count, limit;
  integer seed;

  adc_input_top adc_input_top_inst (.*);

  initial begin
    clk_adc = 1'b0;
    forever #50 clk_adc = ~clk_adc;               // 100 ns period
  end

  task automatic check_beat(input string name, input adc_stream_pkg::beat_t got, exp);
    if (got !== exp) begin
      beat_errs++;
      $display("Error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_lane(input string name, input adc_lane_pkg::lane_t got, exp);
    if (got !== exp) begin
      lane_errs++;
      $display("Error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_cap(input string name, input adc_stream_pkg::cap_word_t got, exp);
    if (got !== exp) begin
      cap_errs++;
      $display("Error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      bit_errs++;
      $display("Error %s got %h expected %h", name, got, exp);
    end
  endtask

  // bit j of lane k rides at j*9+k on the deserializer bus
  function automatic logic [adc_lane_pkg::RAW_BITS-1:0] pack_bus(
      input adc_lane_pkg::lane_t [adc_lane_pkg::NUM_LANES-1:0] l);
    logic [adc_lane_pkg::RAW_BITS-1:0] bus;
    for (int k = 0; k < adc_lane_pkg::NUM_LANES; k++) begin
      for (int j = 0; j < adc_lane_pkg::LANE_BITS; j++) begin
        bus[j*adc_lane_pkg::NUM_LANES+k] = l[k][j];
      end
    end
    return bus;
  endfunction

  task automatic report_and_finish();
    int assert_errs;
    assert_errs = adc_input_top_inst.assertions_inst.fail_count;
    $display("errors: beat=%0d lane=%0d cap=%0d bit=%0d other=%0d assert=%0d",
             beat_errs, lane_errs, cap_errs, bit_errs, other_errs, assert_errs);
    if (beat_errs + lane_errs + cap_errs + bit_errs + other_errs + assert_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // one clock: sample outputs at the falling edge, then play the consumer
  task automatic cycle();
    @(negedge clk_adc);
    if (ret_credit) begin
      ret_pulses++;
      win_credits++;                              // window regains a slot
    end
    if (win_credits > adc_stream_pkg::FIFO_DEPTH) begin
      other_errs++;
      $display("window credits rose above the FIFO depth");
    end
    if (dn_valid) begin
      dn_count++;
      owed++;                                     // consumer frees this slot later
      if (exp_beats.size() == 0) begin
        other_errs++;
        $display("dn_valid without any beat sent by the window");
      end else begin
        check_beat("dn_data", dn_data, exp_beats.pop_front());
        check_bit("dn_last", dn_last, exp_lasts.pop_front());
      end
    end
    if (dn_count > granted) begin
      other_errs++;
      $display("more downstream beats than credits granted");
    end
    dn_credit = 1'b0;
    if (hold_cycles > 0) hold_cycles--;           // back-pressure window
    else if (owed > 0 && gap > 0) gap--;
    else if (owed > 0) begin
      dn_credit = 1'b1;
      owed--;
      granted++;
      gap = int'($unsigned($random(seed)) % 4);
    end
  endtask

  // win feed is due one clock after a word, bitslip two clocks after
  task automatic check_pending();
    if (p1_valid) begin
      for (int n = 0; n < adc_lane_pkg::NUM_CHANNELS; n++) begin
        check_lane($sformatf("win_data[%0d]", n), win_data[n][adc_lane_pkg::LANE_BITS-1:0],
                   p1_lanes[n]);
        check_bit($sformatf("win_data[%0d] pad", n),
                  |win_data[n][adc_stream_pkg::SAMPLE_BITS-1:adc_lane_pkg::LANE_BITS], 1'b0);
      end
      check_bit("win_valid", win_valid, p1_s);
      check_bit("win_last", win_last, p1_f);
    end
    if (p2_valid) check_bit("bitslip", bitslip, p2_e);
    p2_valid = p1_valid;
    p2_e     = p1_e;
    p1_valid = 1'b0;
  endtask

  task automatic run_return(input int n);
    int b;
    b = 0;
    hold_cycles = 24;                             // let the FIFO fill first
    while (b < n) begin
      cycle();
      ret_valid = 1'b0;
      if (win_credits > 0) begin
        for (int c = 0; c < adc_lane_pkg::NUM_CHANNELS; c++) begin
          ret_data[c] = {b[7:0], c[3:0], 4'ha};
        end
        ret_last = (b % 3 == 2) || (b == n - 1);
        ret_valid = 1'b1;
        exp_beats.push_back(ret_data);
        exp_lasts.push_back(ret_last);
        win_credits--;
        b++;
      end
    end
    cycle();
    ret_valid = 1'b0;
    while (exp_beats.size() > 0) cycle();
    if (ret_pulses != dn_count) begin
      other_errs++;
      $display("ret_credit pulses %0d do not match %0d forwarded beats", ret_pulses, dn_count);
    end
  endtask

  task automatic run_capture(input logic [2:0] sel);
    adc_stream_pkg::cap_word_t exp_cap[adc_stream_pkg::CAPTURE_DEPTH];
    adc_lane_pkg::lane_t [adc_lane_pkg::NUM_LANES-1:0] lw;
    cycle();
    capture_sel = sel;
    capture_go  = 1'b1;
    cycle();
    capture_go = 1'b0;
    while (sel == adc_stream_pkg::SEL_RETURN && win_credits == 0) cycle();
    for (int k = 0; k < adc_stream_pkg::CAPTURE_DEPTH; k++) begin
      cycle();
      exp_cap[k] = 16'((k * 37 + int'(sel) * 5 + 3) & 'h3ff);
      if (sel == adc_stream_pkg::SEL_RETURN) begin
        ret_data    = '0;
        ret_data[0] = exp_cap[k];
        ret_valid   = (k == 0);                   // the frame end beat
        ret_last    = (k == 0);
        if (k == 0) begin
          exp_beats.push_back(ret_data);
          exp_lasts.push_back(1'b1);
          win_credits--;
        end
      end else begin
        lw = '0;
        lw[sel] = exp_cap[k][adc_lane_pkg::LANE_BITS-1:0];
        lw[adc_lane_pkg::FRAME_LANE] = adc_lane_pkg::FRAME_PATTERN;
        data_in    = pack_bus(lw);
        sampling   = (k == 0);
        frame_last = (k == 0);
      end
    end
    cycle();
    ret_valid  = 1'b0;
    sampling   = 1'b0;
    frame_last = 1'b0;
    while (!capture_done) cycle();
    check_bit("capture_busy", capture_busy, 1'b0);
    for (int a = 0; a <= adc_stream_pkg::CAPTURE_DEPTH; a++) begin
      cycle();
      if (a > 0) check_cap($sformatf("cap_rd_data[%0d]", a - 1), cap_rd_data, exp_cap[a-1]);
      if (a < adc_stream_pkg::CAPTURE_DEPTH) cap_rd_addr = a[adc_stream_pkg::CAP_ADDR_BITS-1:0];
    end
    while (exp_beats.size() > 0) cycle();
  endtask

  // watchdog, limit set once the trace is read
  initial begin
    cycle_count = 0;
    wait (limit > 0);
    while (cycle_count < limit) begin
      @(posedge clk_adc);
      cycle_count++;
    end
    other_errs++;
    $display("timeout after %0d cycles", cycle_count);
    report_and_finish();
  end

  initial begin
    string line, lines[$];
    integer fd, r;
    int v[12];
    int total;
    adc_lane_pkg::lane_t [adc_lane_pkg::NUM_LANES-1:0] lw;
    seed = 47474;
    limit = 0;
    {beat_errs, lane_errs, cap_errs, bit_errs, other_errs} = '0;
    {win_credits, ret_pulses, dn_count, owed, gap, hold_cycles} = '0;
    win_credits = int'(adc_stream_pkg::WIN_CREDITS);
    granted     = int'(adc_stream_pkg::DN_CREDITS);
    {p1_valid, p1_s, p1_f, p1_e, p2_valid, p2_e} = '0;
    rst_adc_n = 1'b0;
    lw = '0;
    lw[adc_lane_pkg::FRAME_LANE] = adc_lane_pkg::FRAME_PATTERN; // aligned idle frame
    data_in = pack_bus(lw);
    {sampling, frame_last, ret_valid, ret_last, dn_credit, capture_go} = '0;
    ret_data    = '0;
    capture_sel = '0;
    cap_rd_addr = '0;
    fd = $fopen("adc_input_trace.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open the trace file");
    end else begin
      while (!$feof(fd)) begin
        r = $fgets(line, fd);
        if (r > 0 && line.len() > 1 && line[0] != "#") lines.push_back(line);
      end
      $fclose(fd);
    end
    total = 40;                                   // reset plus drain
    foreach (lines[i]) begin
      r = $sscanf(lines[i].substr(2, lines[i].len() - 1), "%d", v[0]);
      if (lines[i][0] == "L") total += 1;
      else if (lines[i][0] == "R") total += 40 + 8 * v[0];
      else total += 3 * adc_stream_pkg::CAPTURE_DEPTH + 20;
    end
    limit = 2 * total;
    repeat (4) @(posedge clk_adc);
    @(negedge clk_adc);
    rst_adc_n = 1'b1;
    foreach (lines[i]) begin
      if (lines[i][0] == "L") begin
        r = $sscanf(lines[i], "L %h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                    v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
        cycle();
        check_pending();
        for (int k = 0; k < adc_lane_pkg::NUM_LANES; k++) lw[k] = v[3+k][9:0];
        data_in    = pack_bus(lw);
        sampling   = v[0][0];
        frame_last = v[1][0];
        {p1_valid, p1_s, p1_f, p1_e} = {1'b1, v[0][0], v[1][0], v[2][0]};
        p1_lanes   = lw;
      end else begin
        repeat (2) begin
          cycle();
          check_pending();
        end
        sampling   = 1'b0;
        frame_last = 1'b0;
        r = $sscanf(lines[i].substr(2, lines[i].len() - 1), "%d", v[0]);
        if (lines[i][0] == "R") run_return(v[0]);
        else run_capture(v[0][2:0]);
      end
    end
    repeat (2) begin
      cycle();
      check_pending();
    end
    report_and_finish();
  end

endmodule

// File: adc_input_trace.txt
# L sampling frame_last bitslip_two_cycles_later lane0 .. lane7 frame_lane (hex)
# R beats_to_return (decimal), C capture_select (decimal)
L 1 0 0 001 002 003 004 005 006 007 008 3e0
L 1 1 0 3ff 200 155 2aa 0f0 30f 111 222 3e0
L 1 0 1 123 234 345 056 167 278 389 09a 1f0
L 0 0 0 100 080 040 020 010 008 004 002 1f0
L 1 0 0 2b3 1c4 0d5 3e6 2f7 108 019 32a 3c1
L 1 1 0 000 3ff 000 3ff 000 3ff 000 3ff 000
L 0 0 0 155 155 155 155 155 155 155 155 3ff
L 1 0 1 0aa 0bb 0cc 0dd 0ee 0ff 011 022 3f0
L 1 0 0 321 132 213 031 103 310 0f1 1f2 3e0
L 1 1 0 05a 0a5 15a 1a5 25a 2a5 35a 3a5 3e0
L 0 0 0 3c3 0c3 33c 03c 3cc 0cc 333 033 2e0
L 1 0 0 00f 0f0 0ff 1f1 2f2 3f3 0e0 1e1 3e0
L 1 0 1 1aa 2bb 3cc 0dd 1ee 2ff 300 011 3e1
L 1 1 0 018 029 03a 04b 05c 06d 07e 08f 3e0
R 20
C 5
C 1

// File: adc_input_top.f
adc_lane_pkg.sv
adc_stream_pkg.sv
adc_lane_unpack.sv
frame_slip_detect.sv
return_fifo.sv
stream_credit_tx.sv
capture_ctrl.sv
capture_ram.sv
adc_input_top.sv
adc_input_assertions.sv
adc_input_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the front end testbench with Verilator
verilator --binary --assert -j 0 --top-module adc_input_tb -f adc_input_top.f -o adc_input_sim \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/adc_input_sim)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
